//--- files.f
+incdir+test
rtl/fpu_aux_pkg.sv
rtl/fpu_aux_issue.sv
rtl/fpu_i2f.sv
rtl/fpu_fmin_fmax.sv
rtl/fpu_float_aux.sv
rtl/fpu_aux_writeback.sv
rtl/fpu_aux_top.sv
test/tb_fpu_aux.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fpu_aux -f files.f -Mdir build/obj
./build/obj/Vtb_fpu_aux | tee build/sim.log

if grep -q "Something failed" build/sim.log; then
  echo "simulation reported errors, see build/sim.log"
  exit 1
fi
echo "simulation passed"

//--- test/fpu_aux_model.svh
`ifndef FPU_AUX_MODEL_SVH
`define FPU_AUX_MODEL_SVH

// xorshift32 with shifts 13, 17, 5.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  return x ^ (x << 5);
endfunction

function automatic logic is_nan(input logic [31:0] x);
  return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
endfunction

// unsigned key in float order, -0 just below +0.
function automatic logic [31:0] order_key(input logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

// returns {flags, result}.
function automatic logic [36:0] min_max(input logic [31:0] a, input logic [31:0] b,
                                        input logic want_min);
  logic [4:0]  fl;
  logic [31:0] r;
  fl = ((is_nan(a) && !a[22]) || (is_nan(b) && !b[22])) ? 5'b10000 : 5'b00000;
  r  = (is_nan(a) && is_nan(b))                   ? 32'h7fc0_0000 :
       is_nan(a)                                  ? b :
       is_nan(b)                                  ? a :
       ((order_key(a) < order_key(b)) == want_min) ? a : b;
  return {fl, r};
endfunction

// returns {inexact, result}.
function automatic logic [32:0] int_to_float(input logic [31:0] v, input logic is_signed,
                                             input logic [2:0] rm);
  logic        neg;
  logic [31:0] m;
  logic [31:0] rest;
  logic [31:0] half;
  logic [32:0] kept;
  logic        nx;
  logic        up;
  int          top;
  int          drop;
  neg = is_signed && v[31];
  m   = neg ? (~v + 32'd1) : v;
  if (m == 32'd0) begin
    return 33'd0;
  end
  top = 31;
  while (!m[top]) begin
    top--;
  end
  drop = (top > 23) ? top - 23 : 0; // 24 bits fit exactly.
  if (drop > 0) begin
    kept = {1'b0, m >> drop};
  end else begin
    kept = {1'b0, m << (23 - top)}; // hidden bit up to bit 23.
  end
  rest = m & ((32'd1 << drop) - 32'd1);
  half = (drop > 0) ? (32'd1 << (drop - 1)) : 32'd0;
  nx   = (rest != 32'd0);
  case (rm)
    3'd0:    up = nx && ((rest > half) || ((rest == half) && kept[0]));
    3'd2:    up = nx && neg;
    3'd3:    up = nx && !neg;
    3'd4:    up = nx && (rest >= half);
    default: up = 1'b0;
  endcase
  kept = kept + {32'd0, up};
  if (kept[24]) begin
    kept = kept >> 1; // rounded up to the next power of two.
    top++;
  end
  return {nx, neg, 8'(top + 127), kept[22:0]};
endfunction

`endif

//--- test/tb_fpu_aux.sv
`timescale 1ns/1ns

module tb_fpu_aux;
  import fpu_aux_pkg::*;

  localparam int period_c  = 4;
  localparam int reset_c   = 10;
  localparam int ops_c     = 4000;
  localparam int drain_c   = 6;
  localparam int timeout_c = (reset_c + ops_c + drain_c) * period_c + 400;

  logic          clk_i;
  logic          arst_n_i;
  logic          v_i;
  fpu_float_op_e op_i;
  fp_word_t      rs1_i;
  fp_word_t      rs2_i;
  frm_e          rm_i;
  frm_e          frm_i;
  logic          fflags_clear_i;
  logic          v_o;
  fp_word_t      result_o;
  fflags_t       fflags_o;
  fflags_t       fflags_acc_o;

  logic [31:0] rng_state;
  logic [31:0] prev_operand;
  int          cycle;
  logic        checking;
  logic        clear_log [0:ops_c+drain_c];
  int          due_q[$];
  logic [36:0] exp_q[$];
  fflags_t     acc_model;
  int          value_errs;
  int          proto_errs;

  `include "fpu_aux_model.svh"

  fpu_aux_top #(.data_width_p(32)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(period_c / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // biased toward nans, zeros, repeats and rounding ties.
  function automatic logic [31:0] pick_operand();
    logic [31:0] sel;
    logic [31:0] v;
    logic [31:0] x;
    sel = next_rand();
    v   = next_rand();
    case (sel[3:0])
      4'd0:    x = {v[31], 8'hff, 1'b1, v[21:0]};       // quiet nan.
      4'd1:    x = {v[31], 8'hff, 1'b0, v[21:1], 1'b1}; // signaling nan.
      4'd2:    x = 32'h0000_0000;
      4'd3:    x = 32'h8000_0000;
      4'd4:    x = prev_operand;
      4'd5:    x = 32'h0200_0002 | (v & 32'h01ff_fffc); // exact tie above 2^24.
      4'd6:    x = {{16{v[15]}}, v[15:0]};
      default: x = v;
    endcase
    prev_operand = x;
    return x;
  endfunction

  function automatic logic [36:0] expected_of(input fpu_float_op_e op, input fp_word_t a,
                                              input fp_word_t b, input logic [2:0] rm);
    logic [32:0] cvt;
    case (op)
      e_fmin:   return min_max(a, b, 1'b1);
      e_fmax:   return min_max(a, b, 1'b0);
      e_fsgnj:  return {5'd0, b[31], a[30:0]};
      e_fsgnjn: return {5'd0, ~b[31], a[30:0]};
      e_fsgnjx: return {5'd0, a[31] ^ b[31], a[30:0]};
      e_fcvt_s_w, e_fcvt_s_wu: begin
        cvt = int_to_float(a, op == e_fcvt_s_w, rm);
        return {4'd0, cvt[32], cvt[31:0]};
      end
      default:  return {5'd0, a}; // register move.
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  initial begin
    logic [31:0]   r;
    fpu_float_op_e op;
    fp_word_t      a;
    fp_word_t      b;
    logic [2:0]    rm;
    logic [2:0]    frm;
    logic [2:0]    rm_res;
    logic          take;
    rng_state      = 32'd1436;
    prev_operand   = 32'h3f80_0000;
    cycle          = 0;
    checking       = 1'b0;
    acc_model      = '0;
    value_errs     = 0;
    proto_errs     = 0;
    arst_n_i       <= 1'b0;
    v_i            <= 1'b0;
    op_i           <= e_fmin;
    rs1_i          <= '0;
    rs2_i          <= '0;
    rm_i           <= e_rne;
    frm_i          <= e_rne;
    fflags_clear_i <= 1'b0;
    repeat (reset_c) @(posedge clk_i);
    arst_n_i     <= 1'b1;
    clear_log[0] = 1'b0;
    checking     = 1'b1;
    for (int n = 1; n <= ops_c + drain_c; n++) begin
      @(posedge clk_i);
      cycle = n;
      r     = next_rand();
      op    = (r[6:4] == 3'd0) ? fpu_float_op_e'({1'b1, r[2:0]})
                               : fpu_float_op_e'({1'b0, r[2:0]});
      take  = (n <= ops_c) && (r[11:8] != 4'd0);
      rm    = r[12] ? r[15:13] : (r[15:13] % 3'd5); // reserved codes now and then.
      frm   = r[18:16];
      a     = pick_operand();
      b     = pick_operand();
      clear_log[n] = (r[23:20] == 4'd0);
      v_i            <= take;
      op_i           <= op;
      rs1_i          <= a;
      rs2_i          <= b;
      rm_i           <= frm_e'(rm);
      frm_i          <= frm_e'(frm);
      fflags_clear_i <= clear_log[n];
      rm_res = (rm == 3'd7) ? frm : rm;
      if (take && !op[3] && !((op == e_fcvt_s_w || op == e_fcvt_s_wu) && rm_res > 3'd4)) begin
        due_q.push_back(n + 2);
        exp_q.push_back(expected_of(op, a, b, rm_res));
      end
    end
    @(posedge clk_i);
    $display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // outputs are stable mid-cycle.
  always @(negedge clk_i) begin
    logic        expect_now;
    logic        clr;
    logic [36:0] exp;
    if (checking) begin
      expect_now = (due_q.size() != 0) && (due_q[0] == cycle);
      exp        = expect_now ? exp_q[0] : 37'd0;
      clr        = 1'b0;
      if (cycle > 0) begin
        clr = clear_log[cycle-1];
      end
      if (cycle == 0) begin
        check_value("result after reset", result_o, 32'd0);
        check_value("flags after reset", 32'(fflags_o), 32'd0);
      end
      assert (v_o == expect_now) else begin
        if (v_o) begin
          $display("v_o pulsed at %0t with no operation outstanding", $time);
        end else begin
          $display("result due in cycle %0d did not come out", cycle);
        end
        proto_errs++;
      end
      if (v_o && expect_now) begin
        check_value("result", result_o, exp[31:0]);
        check_value("flags", 32'(fflags_o), 32'(exp[36:32]));
      end
      if (expect_now) begin
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
      end
      acc_model = clr ? exp[36:32] : (acc_model | exp[36:32]);
      check_value("accrued flags", 32'(fflags_acc_o), 32'(acc_model));
    end
  end

  initial begin
    #(timeout_c);
    $display("watchdog expired before the test finished");
    $display("Something failed");
    $finish;
  end

endmodule

//--- rtl/fpu_aux_top.sv
`timescale 1ns/1ns

module fpu_aux_top #(
  parameter int data_width_p = 32
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       v_i,
  input  fpu_aux_pkg::fpu_float_op_e op_i,
  input  fpu_aux_pkg::fp_word_t      rs1_i,
  input  fpu_aux_pkg::fp_word_t      rs2_i,
  input  fpu_aux_pkg::frm_e          rm_i,
  input  fpu_aux_pkg::frm_e          frm_i,
  input  logic                       fflags_clear_i,
  output logic                       v_o,
  output fpu_aux_pkg::fp_word_t      result_o,
  output fpu_aux_pkg::fflags_t       fflags_o,
  output fpu_aux_pkg::fflags_t       fflags_acc_o
);
  import fpu_aux_pkg::*;

  logic          fp_v;
  fpu_float_op_e fp_op;
  fp_word_t      fp_rs1;
  fp_word_t      fp_rs2;
  frm_e          fp_rm;
  logic          aux_v;
  fp_word_t      aux_result;
  fflags_t       aux_fflags;

  fpu_aux_issue issue0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .op_i     (op_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .rm_i     (rm_i),
    .frm_i    (frm_i),
    .v_o      (fp_v),
    .op_o     (fp_op),
    .rs1_o    (fp_rs1),
    .rs2_o    (fp_rs2),
    .rm_o     (fp_rm)
  );

  // combinational stage between the two registers.
  fpu_float_aux #(
    .data_width_p(data_width_p)
  ) aux0 (
    .fp_v_i         (fp_v),
    .fpu_float_op_i (fp_op),
    .fp_rs1_i       (fp_rs1),
    .fp_rs2_i       (fp_rs2),
    .fp_rm_i        (fp_rm),
    .v_o            (aux_v),
    .result_o       (aux_result),
    .fflags_o       (aux_fflags)
  );

  fpu_aux_writeback wb0 (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .v_i            (aux_v),
    .result_i       (aux_result),
    .fflags_i       (aux_fflags),
    .fflags_clear_i (fflags_clear_i),
    .v_o            (v_o),
    .result_o       (result_o),
    .fflags_o       (fflags_o),
    .fflags_acc_o   (fflags_acc_o)
  );

endmodule

//--- rtl/fpu_aux_writeback.sv
`timescale 1ns/1ns

module fpu_aux_writeback (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  v_i,
  input  fpu_aux_pkg::fp_word_t result_i,
  input  fpu_aux_pkg::fflags_t  fflags_i,
  input  logic                  fflags_clear_i,
  output logic                  v_o,
  output fpu_aux_pkg::fp_word_t result_o,
  output fpu_aux_pkg::fflags_t  fflags_o,
  output fpu_aux_pkg::fflags_t  fflags_acc_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_o      <= 1'b0;
      result_o <= '0;
      fflags_o <= '0;
    end else begin
      v_o <= v_i;
      if (v_i) begin
        result_o <= result_i; // held until the next result.
        fflags_o <= fflags_i;
      end
    end
  end

  // sticky accrued flags.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fflags_acc_o <= '0;
    end else if (fflags_clear_i) begin
      fflags_acc_o <= v_i ? fflags_i : '0; // result in the clear cycle survives.
    end else if (v_i) begin
      fflags_acc_o <= fflags_acc_o | fflags_i;
    end
  end

endmodule

//--- rtl/fpu_float_aux.sv
`timescale 1ns/1ns

module fpu_float_aux #(
  parameter int data_width_p = 32
) (
  input  logic                       fp_v_i,
  input  fpu_aux_pkg::fpu_float_op_e fpu_float_op_i,
  input  fpu_aux_pkg::fp_word_t      fp_rs1_i,
  input  fpu_aux_pkg::fp_word_t      fp_rs2_i,
  input  fpu_aux_pkg::frm_e          fp_rm_i,
  output logic                       v_o,
  output fpu_aux_pkg::fp_word_t      result_o,
  output fpu_aux_pkg::fflags_t       fflags_o
);
  import fpu_aux_pkg::*;

  localparam int sign_bit_lp = exp_width_c + sig_width_c;

  logic      is_fmin;
  logic      is_signed_cvt;
  int_word_t int_src;
  fp_word_t  i2f_result;
  fflags_t   i2f_fflags;
  fp_word_t  minmax_result;
  logic      minmax_invalid;
  fp_word_t  fsgnj_result;

  assign is_fmin       = (fpu_float_op_i == e_fmin);
  assign is_signed_cvt = (fpu_float_op_i == e_fcvt_s_w);
  assign int_src       = int_word_t'(fp_rs1_i); // integer operand rides in rs1.

  fpu_i2f #(
    .data_width_p(data_width_p)
  ) i2f0 (
    .signed_i (is_signed_cvt),
    .int_i    (int_src[data_width_p-1:0]),
    .rm_i     (fp_rm_i),
    .result_o (i2f_result),
    .fflags_o (i2f_fflags)
  );

  fpu_fmin_fmax minmax0 (
    .rs1_i           (fp_rs1_i),
    .rs2_i           (fp_rs2_i),
    .fmin_not_fmax_i (is_fmin),
    .invalid_o       (minmax_invalid),
    .result_o        (minmax_result)
  );

  always_comb begin
    fsgnj_result = fp_rs1_i;
    case (fpu_float_op_i)
      e_fsgnj:  fsgnj_result[sign_bit_lp] = fp_rs2_i[sign_bit_lp];
      e_fsgnjn: fsgnj_result[sign_bit_lp] = ~fp_rs2_i[sign_bit_lp];
      e_fsgnjx: fsgnj_result[sign_bit_lp] = fp_rs1_i[sign_bit_lp] ^ fp_rs2_i[sign_bit_lp];
      default:  fsgnj_result[sign_bit_lp] = fp_rs1_i[sign_bit_lp];
    endcase
  end

  always_comb begin
    v_o      = fp_v_i;
    result_o = '0;
    fflags_o = '0;
    case (fpu_float_op_i)
      e_fmin, e_fmax: begin
        result_o             = minmax_result;
        fflags_o[fflag_nv_c] = minmax_invalid;
      end
      e_fcvt_s_w, e_fcvt_s_wu: begin
        result_o = i2f_result;
        fflags_o = i2f_fflags;
      end
      e_fsgnj, e_fsgnjn, e_fsgnjx: begin
        result_o = fsgnj_result;
      end
      e_fmv_w_x: begin
        result_o = fp_word_t'(int_src); // raw bit copy.
      end
      default: begin
        v_o = 1'b0; // unused opcode.
      end
    endcase
  end

endmodule

//--- rtl/fpu_fmin_fmax.sv
`timescale 1ns/1ns

module fpu_fmin_fmax (
  input  fpu_aux_pkg::fp_word_t rs1_i,
  input  fpu_aux_pkg::fp_word_t rs2_i,
  input  logic                  fmin_not_fmax_i,
  output logic                  invalid_o,
  output fpu_aux_pkg::fp_word_t result_o
);
  import fpu_aux_pkg::*;

  localparam int sign_bit_lp = exp_width_c + sig_width_c;

  logic     a_nan;
  logic     b_nan;
  logic     a_snan;
  logic     b_snan;
  logic     a_sign;
  logic     b_sign;
  logic     mag_lt;
  logic     mag_gt;
  logic     a_lt_b;
  fp_word_t ordered;

  assign a_nan  = (&rs1_i[sig_width_c +: exp_width_c]) & (|rs1_i[sig_width_c-1:0]);
  assign b_nan  = (&rs2_i[sig_width_c +: exp_width_c]) & (|rs2_i[sig_width_c-1:0]);
  assign a_snan = a_nan & ~rs1_i[sig_width_c-1]; // quiet bit clear.
  assign b_snan = b_nan & ~rs2_i[sig_width_c-1];

  assign a_sign = rs1_i[sign_bit_lp];
  assign b_sign = rs2_i[sign_bit_lp];
  assign mag_lt = rs1_i[sign_bit_lp-1:0] < rs2_i[sign_bit_lp-1:0];
  assign mag_gt = rs1_i[sign_bit_lp-1:0] > rs2_i[sign_bit_lp-1:0];

  // sign-magnitude order, -0 below +0.
  assign a_lt_b  = (a_sign != b_sign) ? a_sign : (a_sign ? mag_gt : mag_lt);
  assign ordered = (a_lt_b == fmin_not_fmax_i) ? rs1_i : rs2_i;

  always_comb begin
    if (a_nan && b_nan) begin
      result_o = canonical_nan_c;
    end else if (a_nan) begin
      result_o = rs2_i;
    end else if (b_nan) begin
      result_o = rs1_i;
    end else begin
      result_o = ordered;
    end
  end

  assign invalid_o = a_snan | b_snan; // quiet nans pass silently.

endmodule

//--- rtl/fpu_i2f.sv
`timescale 1ns/1ns

module fpu_i2f #(
  parameter int data_width_p = 32
) (
  input  logic                    signed_i,
  input  logic [data_width_p-1:0] int_i,
  input  fpu_aux_pkg::frm_e       rm_i,
  output fpu_aux_pkg::fp_word_t   result_o,
  output fpu_aux_pkg::fflags_t    fflags_o
);
  import fpu_aux_pkg::*;

  localparam int lz_width_lp  = $clog2(data_width_p) + 1;
  localparam int keep_lp      = sig_width_c + 1; // hidden bit plus fraction.
  localparam int pad_lp       = sig_width_c + 3;
  localparam int ext_width_lp = data_width_p + pad_lp;

  logic                    sign;
  logic [data_width_p-1:0] mag;
  logic                    is_zero;
  logic [lz_width_lp-1:0]  lz;
  logic [data_width_p-1:0] norm;
  logic [ext_width_lp-1:0] norm_ext;
  logic [keep_lp-1:0]      sig;
  logic                    guard;
  logic                    sticky;
  logic                    round_up;
  logic [keep_lp:0]        sig_rnd;
  logic [exp_width_c-1:0]  exp_pre;
  logic [exp_width_c-1:0]  exp_fin;

  assign sign    = signed_i & int_i[data_width_p-1];
  assign mag     = sign ? -int_i : int_i; // most negative value maps to itself.
  assign is_zero = (mag == '0);

  // highest set bit wins.
  always_comb begin
    lz = '0;
    for (int i = 0; i < data_width_p; i++) begin
      if (mag[i]) begin
        lz = lz_width_lp'(data_width_p - 1 - i);
      end
    end
  end

  assign norm     = mag << lz;
  assign norm_ext = {norm, {pad_lp{1'b0}}}; // pad so narrow inputs still slice.
  assign sig      = norm_ext[ext_width_lp-1 -: keep_lp];
  assign guard    = norm_ext[ext_width_lp-1-keep_lp];
  assign sticky   = |norm_ext[ext_width_lp-2-keep_lp:0];

  always_comb begin
    case (rm_i)
      e_rne:   round_up = guard & (sticky | sig[0]);
      e_rdn:   round_up = sign & (guard | sticky);
      e_rup:   round_up = ~sign & (guard | sticky);
      e_rmm:   round_up = guard;
      default: round_up = 1'b0; // rtz.
    endcase
  end

  assign sig_rnd = {1'b0, sig} + (keep_lp + 1)'(round_up);
  assign exp_pre = exp_width_c'(exp_bias_c + data_width_p - 1) - exp_width_c'(lz);
  assign exp_fin = exp_pre + exp_width_c'(sig_rnd[keep_lp]); // carry bumps exponent.

  // fraction is all zero after a carry, so no shift needed.
  assign result_o = is_zero ? '0 : {sign, exp_fin, sig_rnd[sig_width_c-1:0]};

  assign fflags_o[fflag_nv_c] = 1'b0;
  assign fflags_o[fflag_dz_c] = 1'b0;
  assign fflags_o[fflag_of_c] = 1'b0; // integers never reach the float limit.
  assign fflags_o[fflag_uf_c] = 1'b0;
  assign fflags_o[fflag_nx_c] = guard | sticky;

endmodule

//--- rtl/fpu_aux_issue.sv
`timescale 1ns/1ns

module fpu_aux_issue (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       v_i,
  input  fpu_aux_pkg::fpu_float_op_e op_i,
  input  fpu_aux_pkg::fp_word_t      rs1_i,
  input  fpu_aux_pkg::fp_word_t      rs2_i,
  input  fpu_aux_pkg::frm_e          rm_i,
  input  fpu_aux_pkg::frm_e          frm_i,
  output logic                       v_o,
  output fpu_aux_pkg::fpu_float_op_e op_o,
  output fpu_aux_pkg::fp_word_t      rs1_o,
  output fpu_aux_pkg::fp_word_t      rs2_o,
  output fpu_aux_pkg::frm_e          rm_o
);
  import fpu_aux_pkg::*;

  frm_e rm_res;
  logic is_cvt;
  logic rm_reserved;

  assign rm_res      = (rm_i == e_dyn) ? frm_i : rm_i; // dynamic mode from csr.
  assign is_cvt      = (op_i == e_fcvt_s_w) || (op_i == e_fcvt_s_wu);
  assign rm_reserved = (rm_res > e_rmm);

  // only conversions round, so only they die on a bad mode.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i & ~(is_cvt & rm_reserved);
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      op_o  <= op_i;
      rs1_o <= rs1_i;
      rs2_o <= rs2_i;
      rm_o  <= rm_res;
    end
  end

endmodule

//--- rtl/fpu_aux_pkg.sv
package fpu_aux_pkg;

  // aux unit operations, other codes unused.
  typedef enum logic [3:0] {
    e_fmin      = 4'd0,
    e_fmax      = 4'd1,
    e_fsgnj     = 4'd2,
    e_fsgnjn    = 4'd3,
    e_fsgnjx    = 4'd4,
    e_fcvt_s_w  = 4'd5,
    e_fcvt_s_wu = 4'd6,
    e_fmv_w_x   = 4'd7
  } fpu_float_op_e;

  // riscv rounding modes. 5 and 6 reserved.
  typedef enum logic [2:0] {
    e_rne = 3'd0,
    e_rtz = 3'd1,
    e_rdn = 3'd2,
    e_rup = 3'd3,
    e_rmm = 3'd4,
    e_dyn = 3'd7
  } frm_e;

  // binary32 layout.
  localparam int exp_width_c = 8;
  localparam int sig_width_c = 23;
  localparam int exp_bias_c  = 127;

  typedef logic [exp_width_c+sig_width_c:0] fp_word_t;
  typedef logic [31:0]                      int_word_t;

  // nv dz of uf nx, top bit down.
  typedef logic [4:0] fflags_t;

  localparam int fflag_nv_c = 4;
  localparam int fflag_dz_c = 3;
  localparam int fflag_of_c = 2;
  localparam int fflag_uf_c = 1;
  localparam int fflag_nx_c = 0;

  localparam fp_word_t canonical_nan_c = 32'h7fc0_0000;

endpackage
